// ==== rtl/fault_stream_pkg.sv ====
// Stream sample definitions

package fault_stream_pkg;

    // Width of one sample on the monitored stream
    localparam int sample_width = 32;

    // Samples are two's complement values, compared signed against the windows
    typedef logic signed [sample_width-1:0] sample_t;

endpackage

// ==== rtl/fault_config_pkg.sv ====
// Fault detector register map

package fault_config_pkg;

    // One software register word
    localparam int register_width = 32;

    typedef logic [register_width-1:0] register_t;

    // Five registers are implemented, the rest of the address space reads zero
    localparam int register_count = 5;
    localparam int address_width = 3;

    // Register map
    localparam logic [address_width-1:0] slow_low_address = address_width'(0);
    localparam logic [address_width-1:0] slow_high_address = address_width'(1);
    localparam logic [address_width-1:0] duration_address = address_width'(2);
    localparam logic [address_width-1:0] fast_low_address = address_width'(3);
    localparam logic [address_width-1:0] fast_high_address = address_width'(4);

    // Only the low bits of the duration word set the slow trip limit
    localparam int duration_width = 8;

endpackage

// ==== rtl/threshold_registers.sv ====
// Threshold and duration register file

`timescale 1ns/1ps

module threshold_registers (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     write_enable,
    input  logic [fault_config_pkg::address_width-1:0] write_address,
    input  fault_config_pkg::register_t              write_data,
    input  logic [fault_config_pkg::address_width-1:0] read_address,
    output fault_config_pkg::register_t              read_data,
    output fault_stream_pkg::sample_t                fast_low,
    output fault_stream_pkg::sample_t                fast_high,
    output fault_stream_pkg::sample_t                slow_low,
    output fault_stream_pkg::sample_t                slow_high,
    output logic [fault_config_pkg::duration_width-1:0] slow_duration
);

    import fault_config_pkg::*;
    import fault_stream_pkg::*;

    register_t registers [register_count];

    logic write_in_range;
    logic read_in_range;

    // Addresses above the last register fall outside the map
    assign write_in_range = write_address < register_count;
    assign read_in_range = read_address < register_count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int index = 0; index < register_count; index++) begin
                registers[index] <= '0;
            end
        end else if (write_enable && write_in_range) begin
            registers[write_address] <= write_data;
        end
    end

    // Reads return the whole stored word, even where only part of it is used
    always_comb begin
        if (read_in_range) begin
            read_data = registers[read_address];
        end else begin
            read_data = '0;
        end
    end

    // Threshold words are taken as signed sample values
    assign slow_low = sample_t'(registers[slow_low_address]);
    assign slow_high = sample_t'(registers[slow_high_address]);
    assign fast_low = sample_t'(registers[fast_low_address]);
    assign fast_high = sample_t'(registers[fast_high_address]);

    assign slow_duration = registers[duration_address][duration_width-1:0];

endmodule

// ==== rtl/sample_window_classifier.sv ====
// Sample window classifier

`timescale 1ns/1ps

module sample_window_classifier (
    input  logic                      clock,
    input  logic                      reset,
    input  fault_stream_pkg::sample_t sample,
    input  logic                      sample_valid,
    input  fault_stream_pkg::sample_t fast_low,
    input  fault_stream_pkg::sample_t fast_high,
    input  fault_stream_pkg::sample_t slow_low,
    input  fault_stream_pkg::sample_t slow_high,
    output logic                      flag_valid,
    output logic                      fast_outside,
    output logic                      slow_outside
);

    logic below_fast;
    logic above_fast;
    logic below_slow;
    logic above_slow;

    // Both operands are signed, so these are signed compares
    // The bounds themselves count as inside the window
    assign below_fast = sample < fast_low;
    assign above_fast = sample > fast_high;
    assign below_slow = sample < slow_low;
    assign above_slow = sample > slow_high;

    // One flagged result per valid sample, back to back samples are fine
    always_ff @(posedge clock) begin
        if (!reset) begin
            flag_valid <= 1'b0;
        end else begin
            flag_valid <= sample_valid;
        end
    end

    // The flags are only looked at while flag_valid is high
    always_ff @(posedge clock) begin
        fast_outside <= below_fast || above_fast;
        slow_outside <= below_slow || above_slow;
    end

endmodule

// ==== rtl/slow_trip_counter.sv ====
// Slow window violation counter

`timescale 1ns/1ps

module slow_trip_counter (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        flag_valid,
    input  logic                                        slow_outside,
    input  logic [fault_config_pkg::duration_width-1:0] slow_duration,
    input  logic                                        counter_hold,
    input  logic                                        counter_clear,
    output logic                                        slow_trip
);

    import fault_config_pkg::*;

    logic [duration_width-1:0] violation_count;

    // Clear wins over hold, since the clear only comes while the fault holds the count
    always_ff @(posedge clock) begin
        if (!reset) begin
            violation_count <= '0;
        end else if (counter_clear) begin
            violation_count <= '0;
        end else if (flag_valid && slow_outside && !counter_hold) begin
            violation_count <= violation_count + 1'b1;
        end
    end

    // A zero duration disables the slow path entirely
    assign slow_trip = (slow_duration != '0) && (violation_count == slow_duration);

endmodule

// ==== rtl/fault_control.sv ====
// Fault latch control

`timescale 1ns/1ps

module fault_control (
    input  logic clock,
    input  logic reset,
    input  logic flag_valid,
    input  logic fast_outside,
    input  logic slow_trip,
    input  logic clear_fault,
    output logic fault,
    output logic counter_hold,
    output logic counter_clear
);

    logic trip;
    logic clear_accepted;

    // Either a flagged fast violation or the slow count reaching its limit
    assign trip = (flag_valid && fast_outside) || slow_trip;

    // A clear only means something while the fault is latched
    assign clear_accepted = fault && clear_fault;

    always_ff @(posedge clock) begin
        if (!reset) begin
            fault <= 1'b0;
        end else if (fault) begin
            if (clear_fault) begin
                fault <= 1'b0;
            end
        end else if (trip) begin
            fault <= 1'b1;
        end
    end

    // The counter freezes for as long as the fault is latched
    assign counter_hold = fault;

    // Zeroes the count at the same edge that lowers the fault
    assign counter_clear = clear_accepted;

endmodule

// ==== rtl/stream_fault_detector.sv ====
// Stream fault detector top level

`timescale 1ns/1ps

module stream_fault_detector (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        write_enable,
    input  logic [fault_config_pkg::address_width-1:0]  write_address,
    input  fault_config_pkg::register_t                 write_data,
    input  logic [fault_config_pkg::address_width-1:0]  read_address,
    output fault_config_pkg::register_t                 read_data,
    input  fault_stream_pkg::sample_t                   sample,
    input  logic                                        sample_valid,
    input  logic                                        clear_fault,
    output logic                                        fault
);

    import fault_config_pkg::*;
    import fault_stream_pkg::*;

    // Programmed windows and slow trip limit
    sample_t fast_low;
    sample_t fast_high;
    sample_t slow_low;
    sample_t slow_high;
    logic [duration_width-1:0] slow_duration;

    // Classifier results, one cycle behind the sample
    logic flag_valid;
    logic fast_outside;
    logic slow_outside;

    // Counter and control handshake
    logic slow_trip;
    logic counter_hold;
    logic counter_clear;

    threshold_registers registers (
        .clock         (clock),
        .reset         (reset),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .read_address  (read_address),
        .read_data     (read_data),
        .fast_low      (fast_low),
        .fast_high     (fast_high),
        .slow_low      (slow_low),
        .slow_high     (slow_high),
        .slow_duration (slow_duration)
    );

    sample_window_classifier classifier (
        .clock        (clock),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .fast_low     (fast_low),
        .fast_high    (fast_high),
        .slow_low     (slow_low),
        .slow_high    (slow_high),
        .flag_valid   (flag_valid),
        .fast_outside (fast_outside),
        .slow_outside (slow_outside)
    );

    slow_trip_counter counter (
        .clock         (clock),
        .reset         (reset),
        .flag_valid    (flag_valid),
        .slow_outside  (slow_outside),
        .slow_duration (slow_duration),
        .counter_hold  (counter_hold),
        .counter_clear (counter_clear),
        .slow_trip     (slow_trip)
    );

    fault_control control (
        .clock         (clock),
        .reset         (reset),
        .flag_valid    (flag_valid),
        .fast_outside  (fast_outside),
        .slow_trip     (slow_trip),
        .clear_fault   (clear_fault),
        .fault         (fault),
        .counter_hold  (counter_hold),
        .counter_clear (counter_clear)
    );

endmodule

// ==== testbench/stream_fault_detector_checker.sv ====
// Fault detector assertions

`timescale 1ns/1ps

module stream_fault_detector_checker (
    input logic clock,
    input logic reset,
    input logic fault,
    input logic clear_fault,
    input logic flag_valid,
    input logic fast_outside,
    input logic slow_trip,
    input logic counter_clear
);

    // Read by the testbench at the end of the run
    int assertion_failures = 0;

    logic fast_trip;

    assign fast_trip = flag_valid && fast_outside;

    // With no trip pending the fault cannot appear on its own
    fault_stays_low: assert property (@(posedge clock) disable iff (!reset)
        (!fault && !fast_trip && !slow_trip) |=> !fault)
    else begin
        assertion_failures++;
        $error("fault rose without a flagged trip");
    end

    // The latched fault only drops through a clear
    fault_held_until_clear: assert property (@(posedge clock) disable iff (!reset)
        (fault && !clear_fault) |=> fault)
    else begin
        assertion_failures++;
        $error("fault fell without clear_fault");
    end

    // The count is only zeroed while latched, at the edge that drops the fault
    counter_clear_while_fault: assert property (@(posedge clock) disable iff (!reset)
        counter_clear |-> fault ##1 !fault)
    else begin
        assertion_failures++;
        $error("counter_clear pulsed without a latched fault being cleared");
    end

    // Fast path takes exactly one more edge once the flag is out
    fast_trip_sets_fault: assert property (@(posedge clock) disable iff (!reset)
        (!fault && fast_trip) |=> fault)
    else begin
        assertion_failures++;
        $error("flagged fast violation did not set fault");
    end

endmodule

bind stream_fault_detector stream_fault_detector_checker assertion_checks (
    .clock         (clock),
    .reset         (reset),
    .fault         (fault),
    .clear_fault   (clear_fault),
    .flag_valid    (flag_valid),
    .fast_outside  (fast_outside),
    .slow_trip     (slow_trip),
    .counter_clear (counter_clear)
);

// ==== testbench/stream_fault_detector_tb.sv ====
// Stream fault detector testbench

`timescale 1ns/1ps

module stream_fault_detector_tb;

    import fault_config_pkg::*;
    import fault_stream_pkg::*;

    localparam int reset_cycles = 10;
    localparam int timeout_margin = 50;
    localparam int unsigned random_seed = 32'h136a_6fab;

    typedef enum {
        op_write,
        op_read,
        op_sample,
        op_filler,
        op_idle,
        op_clear
    } operation_t;

    // For reads the expected column is the word, otherwise it is the fault level
    // seen at the falling edge where the entry is applied
    typedef struct {
        operation_t operation;
        int         address;
        register_t  value;
        register_t  expected;
    } entry_t;

    logic clock;
    logic reset;
    logic write_enable;
    logic [address_width-1:0] write_address;
    register_t write_data;
    logic [address_width-1:0] read_address;
    register_t read_data;
    sample_t sample;
    logic sample_valid;
    logic clear_fault;
    logic fault;

    entry_t stimulus_table[$];
    int timeout_limit = 1000;
    int cycle_count = 0;

    // Reference model state
    register_t model_registers [register_count];
    logic model_fault;
    logic [duration_width-1:0] model_count;
    logic model_flag_valid;
    logic model_fast_outside;
    logic model_slow_outside;

    stream_fault_detector dut (
        .clock         (clock),
        .reset         (reset),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .read_address  (read_address),
        .read_data     (read_data),
        .sample        (sample),
        .sample_valid  (sample_valid),
        .clear_fault   (clear_fault),
        .fault         (fault)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count >= timeout_limit) begin
                $display("TB FAILED");
                $fatal(1, "Run did not finish within %0d cycles", timeout_limit);
            end
        end
    end

    task automatic check_fault(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR: %s actual 0x%h expected 0x%h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Fault level mismatch");
        end
    endtask

    task automatic check_read_data(input register_t actual, input register_t expected);
        if (actual !== expected) begin
            $display("ERROR: read_data actual 0x%h expected 0x%h", actual, expected);
            $display("TB FAILED");
            $fatal(1, "Read data mismatch");
        end
    endtask

    function automatic logic is_outside(sample_t value, sample_t low, sample_t high);
        return (value < low) || (value > high);
    endfunction

    function automatic register_t expected_read_word(int address);
        if (address < register_count) begin
            return model_registers[address];
        end
        return '0;
    endfunction

    task automatic reset_model();
        for (int index = 0; index < register_count; index++) begin
            model_registers[index] = '0;
        end
        model_fault = 1'b0;
        model_count = '0;
        model_flag_valid = 1'b0;
        model_fast_outside = 1'b0;
        model_slow_outside = 1'b0;
    endtask

    // One rising edge of the detector rules, using the inputs driven this cycle
    task automatic advance_model();
        logic [duration_width-1:0] duration;
        logic slow_trip;
        logic next_fault;
        duration = model_registers[duration_address][duration_width-1:0];
        slow_trip = (duration != 0) && (model_count == duration);
        next_fault = model_fault;
        if (model_fault) begin
            if (clear_fault) begin
                next_fault = 1'b0;
            end
        end else if ((model_flag_valid && model_fast_outside) || slow_trip) begin
            next_fault = 1'b1;
        end
        if (model_fault && clear_fault) begin
            model_count = '0;
        end else if (model_flag_valid && model_slow_outside && !model_fault) begin
            model_count = model_count + 1'b1;
        end
        model_flag_valid = sample_valid;
        model_fast_outside = is_outside(sample, sample_t'(model_registers[fast_low_address]),
                                        sample_t'(model_registers[fast_high_address]));
        model_slow_outside = is_outside(sample, sample_t'(model_registers[slow_low_address]),
                                        sample_t'(model_registers[slow_high_address]));
        if (write_enable && write_address < register_count) begin
            model_registers[write_address] = write_data;
        end
        model_fault = next_fault;
    endtask

    task automatic add_entry(input operation_t operation, input int address,
                             input register_t value, input register_t expected);
        entry_t entry;
        entry.operation = operation;
        entry.address = address;
        entry.value = value;
        entry.expected = expected;
        stimulus_table.push_back(entry);
    endtask

    task automatic build_table();
        // Program the windows, then read everything back including the holes
        add_entry(op_write, slow_low_address, -100, 0);
        add_entry(op_write, slow_high_address, 100, 0);
        add_entry(op_write, duration_address, 32'ha5a5_0003, 0);
        add_entry(op_write, fast_low_address, -1000, 0);
        add_entry(op_write, fast_high_address, 1000, 0);
        add_entry(op_write, 5, 32'hdead_beef, 0);
        add_entry(op_write, 7, 32'h1234_5678, 0);
        add_entry(op_read, slow_low_address, 0, 32'hffff_ff9c);
        add_entry(op_read, slow_high_address, 0, 32'h0000_0064);
        add_entry(op_read, duration_address, 0, 32'ha5a5_0003);
        add_entry(op_read, fast_low_address, 0, 32'hffff_fc18);
        add_entry(op_read, fast_high_address, 0, 32'h0000_03e8);
        add_entry(op_read, 5, 0, 0);
        add_entry(op_read, 6, 0, 0);
        add_entry(op_read, 7, 0, 0);
        // In-window traffic, the bounds themselves are inside
        repeat (6) add_entry(op_filler, 0, 0, 0);
        add_entry(op_sample, 0, 100, 0);
        add_entry(op_sample, 0, -100, 0);
        repeat (2) add_entry(op_filler, 0, 0, 0);
        // Fast trip below the low bound, then violations while latched
        add_entry(op_sample, 0, -1001, 0);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_idle, 0, 0, 1);
        add_entry(op_sample, 0, 5000, 1);
        add_entry(op_sample, 0, -5000, 1);
        add_entry(op_idle, 0, 0, 1);
        add_entry(op_idle, 0, 0, 1);
        add_entry(op_clear, 0, 0, 1);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_clear, 0, 0, 0);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_idle, 0, 0, 0);
        // Fast trip above the high bound
        add_entry(op_sample, 0, 1001, 0);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_idle, 0, 0, 1);
        add_entry(op_clear, 0, 0, 1);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_filler, 0, 0, 0);
        // Slow trip on the third valid violation, the invalid one is not counted
        add_entry(op_sample, 0, 200, 0);
        add_entry(op_filler, 0, 0, 0);
        add_entry(op_sample, 0, -200, 0);
        add_entry(op_idle, 0, 300, 0);
        add_entry(op_sample, 0, 150, 0);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_idle, 0, 0, 1);
        add_entry(op_sample, 0, 500, 1);
        add_entry(op_idle, 0, 0, 1);
        add_entry(op_idle, 0, 0, 1);
        add_entry(op_clear, 0, 0, 1);
        add_entry(op_idle, 0, 0, 0);
        // Count restarts from zero after the clear
        add_entry(op_sample, 0, 200, 0);
        add_entry(op_sample, 0, 200, 0);
        repeat (3) add_entry(op_idle, 0, 0, 0);
        add_entry(op_sample, 0, -150, 0);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_idle, 0, 0, 0);
        add_entry(op_idle, 0, 0, 1);
        add_entry(op_clear, 0, 0, 1);
        add_entry(op_idle, 0, 0, 0);
        // A zero duration turns the slow path off
        add_entry(op_write, duration_address, 0, 0);
        add_entry(op_read, duration_address, 0, 0);
        repeat (6) add_entry(op_sample, 0, 300, 0);
        repeat (3) add_entry(op_idle, 0, 0, 0);
        add_entry(op_read, slow_low_address, 0, 32'hffff_ff9c);
    endtask

    task automatic drive_entry(input entry_t entry);
        int unsigned offset;
        write_enable = 1'b0;
        sample_valid = 1'b0;
        clear_fault = 1'b0;
        sample = sample_t'(entry.value);
        case (entry.operation)
            op_write: begin
                write_enable = 1'b1;
                write_address = entry.address[address_width-1:0];
                write_data = entry.value;
            end
            op_read: begin
                read_address = entry.address[address_width-1:0];
            end
            op_sample: begin
                sample_valid = 1'b1;
            end
            op_filler: begin
                // Anywhere in the slow window, which sits inside the fast one
                offset = $urandom_range(200);
                sample = sample_t'(offset) - 100;
                sample_valid = 1'b1;
            end
            op_clear: begin
                clear_fault = 1'b1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic apply_entry(input entry_t entry);
        check_fault("fault", fault, model_fault);
        if (entry.operation != op_read) begin
            check_fault("fault", fault, entry.expected[0]);
        end
        drive_entry(entry);
        if (entry.operation == op_read) begin
            #1;
            check_read_data(read_data, entry.expected);
            check_read_data(read_data, expected_read_word(entry.address));
        end
        @(posedge clock);
        advance_model();
        @(negedge clock);
    endtask

    initial begin
        reset = 1'b0;
        write_enable = 1'b0;
        write_address = '0;
        write_data = '0;
        read_address = '0;
        sample = '0;
        sample_valid = 1'b0;
        clear_fault = 1'b0;
        void'($urandom(random_seed));
        build_table();
        timeout_limit = stimulus_table.size() + reset_cycles + timeout_margin;
        reset_model();
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        foreach (stimulus_table[index]) begin
            apply_entry(stimulus_table[index]);
        end
        check_fault("fault", fault, model_fault);
        if (dut.assertion_checks.assertion_failures == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "Assertions failed during the run");
        end
    end

endmodule

// ==== verilog.f ====
rtl/fault_stream_pkg.sv
rtl/fault_config_pkg.sv
rtl/threshold_registers.sv
rtl/sample_window_classifier.sv
rtl/slow_trip_counter.sv
rtl/fault_control.sv
rtl/stream_fault_detector.sv
testbench/stream_fault_detector_checker.sv
testbench/stream_fault_detector_tb.sv
